// File: cp0Pkg.sv
package cp0Pkg;

	////////////////////////////////////////////////////////////////////
	// Data and field types
	////////////////////////////////////////////////////////////////////

	// Data words, PC and raw instruction words
	typedef logic [31:0] word;

	// CP0 register number from the rd field
	typedef logic [4:0] regNum;

	// Exception code as stored in Cause bits 6:2
	typedef logic [4:0] excCode;

	// Hardware interrupt lines IP7..IP2
	typedef logic [5:0] intLines;

	// Primary opcode and funct fields
	typedef logic [5:0] opcodeField;
	typedef logic [5:0] functField;

	// rs and rt sub-code fields
	typedef logic [4:0] rsField;

	// Operation that CP0 carries out for the execute instruction
	typedef enum logic [1:0]
	{
		opNone,
		opMtc0,
		opMfc0,
		opEret
	} cp0Op;

	////////////////////////////////////////////////////////////////////
	// Register numbers and reset values
	////////////////////////////////////////////////////////////////////

	localparam regNum regSr = 5'd12;
	localparam regNum regCause = 5'd13;
	localparam regNum regEpc = 5'd14;
	localparam regNum regPrid = 5'd15;

	// IE set and EXL clear
	localparam word srReset = 32'h0000_0001;

	// Fixed processor id
	localparam word pridValue = 32'h0001_8d02;

	// Code used for all hardware interrupts
	localparam excCode excInterrupt = 5'd0;

	////////////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////////////

	// Primary opcodes
	localparam opcodeField opcSpecial = 6'b000000;
	localparam opcodeField opcRegimm = 6'b000001;
	localparam opcodeField opcJ = 6'b000010;
	localparam opcodeField opcJal = 6'b000011;
	localparam opcodeField opcBeq = 6'b000100;
	localparam opcodeField opcBne = 6'b000101;
	localparam opcodeField opcBlez = 6'b000110;
	localparam opcodeField opcBgtz = 6'b000111;
	localparam opcodeField opcCop0 = 6'b010000;

	// COP0 sub-codes in the rs field
	localparam rsField rsMfc0 = 5'b00000;
	localparam rsField rsMtc0 = 5'b00100;
	// eret has the CO bit set and nothing else
	localparam rsField rsEret = 5'b10000;

	// REGIMM branches in the rt field
	localparam rsField rtBltz = 5'b00000;
	localparam rsField rtBgez = 5'b00001;

	// funct codes
	localparam functField functJr = 6'b001000;
	localparam functField functJalr = 6'b001001;
	localparam functField functEret = 6'b011000;

endpackage

// File: instrDecode.sv
`timescale 1ns/10ps

module instrDecode
(
	input cp0Pkg::word instr,
	input cp0Pkg::word wbInstr,
	output cp0Pkg::cp0Op op,
	output cp0Pkg::regNum regSel,
	output logic wbDelay
);

	// Fields of the execute instruction
	cp0Pkg::opcodeField opcode;
	cp0Pkg::rsField rs;
	cp0Pkg::functField funct;

	// Fields of the writeback instruction
	cp0Pkg::opcodeField wbOpcode;
	cp0Pkg::rsField wbRt;
	cp0Pkg::functField wbFunct;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign funct = instr[5:0];

	assign wbOpcode = wbInstr[31:26];
	assign wbRt = wbInstr[20:16];
	assign wbFunct = wbInstr[5:0];

	// CP0 register always comes from rd
	assign regSel = instr[15:11];

	//////////////////////////////////////////////////////////////////////
	// CP0 operation of the execute instruction
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		op = cp0Pkg::opNone;
		if (opcode == cp0Pkg::opcCop0)
		begin
			case (rs)
				cp0Pkg::rsMtc0:
				begin
					op = cp0Pkg::opMtc0;
				end
				cp0Pkg::rsMfc0:
				begin
					op = cp0Pkg::opMfc0;
				end
				cp0Pkg::rsEret:
				begin
					// Other CO functions like tlbwi are not ours
					if (funct == cp0Pkg::functEret)
					begin
						op = cp0Pkg::opEret;
					end
				end
				default:
				begin
					op = cp0Pkg::opNone;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control transfer in writeback
	//////////////////////////////////////////////////////////////////////

	// The instruction after a jump or branch sits in its delay slot
	always_comb
	begin
		case (wbOpcode)
			cp0Pkg::opcJ,
			cp0Pkg::opcJal,
			cp0Pkg::opcBeq,
			cp0Pkg::opcBne,
			cp0Pkg::opcBlez,
			cp0Pkg::opcBgtz:
			begin
				wbDelay = 1'b1;
			end
			cp0Pkg::opcSpecial:
			begin
				wbDelay = (wbFunct == cp0Pkg::functJr) || (wbFunct == cp0Pkg::functJalr);
			end
			cp0Pkg::opcRegimm:
			begin
				wbDelay = (wbRt == cp0Pkg::rtBltz) || (wbRt == cp0Pkg::rtBgez);
			end
			default:
			begin
				wbDelay = 1'b0;
			end
		endcase
	end

endmodule

// File: excPriority.sv
`timescale 1ns/10ps

module excPriority
(
	input logic err,
	input cp0Pkg::excCode errStat,
	input cp0Pkg::intLines hwInt,
	input logic ie,
	input logic exl,
	output logic excTaken,
	output cp0Pkg::excCode code
);

	logic anyInt;
	logic request;
	logic enabled;

	// Any pending hardware line counts
	assign anyInt = |hwInt;

	// Interrupts and the internal error share one request
	assign request = err | anyInt;

	// Global enable and not already in a handler
	assign enabled = ie & ~exl;

	assign excTaken = request & enabled;

	//////////////////////////////////////////////////////////////////////
	// Cause code
	//////////////////////////////////////////////////////////////////////

	// Hardware interrupts beat the internal error
	always_comb
	begin
		if (anyInt)
		begin
			code = cp0Pkg::excInterrupt;
		end
		else
		begin
			code = errStat;
		end
	end

endmodule

// File: cp0Regs.sv
`timescale 1ns/10ps

module cp0Regs
(
	input logic clk,
	input logic reset,
	input cp0Pkg::cp0Op op,
	input cp0Pkg::regNum regSel,
	input logic wbDelay,
	input cp0Pkg::word pc,
	input cp0Pkg::word dataIn,
	input cp0Pkg::intLines hwInt,
	input logic excTaken,
	input cp0Pkg::excCode code,
	output logic ie,
	output logic exl,
	output cp0Pkg::word dataOut
);

	// Architectural registers
	cp0Pkg::word sr;
	cp0Pkg::word cause;
	cp0Pkg::word epc;
	cp0Pkg::word prid;

	// Values loaded on exception entry
	cp0Pkg::word alignedPc;
	cp0Pkg::word excEpc;
	cp0Pkg::word excCause;

	// Decoded write strobes
	logic isEret;
	logic writeSr;
	logic writeEpc;

	assign isEret = (op == cp0Pkg::opEret);
	assign writeSr = (op == cp0Pkg::opMtc0) && (regSel == cp0Pkg::regSr);
	assign writeEpc = (op == cp0Pkg::opMtc0) && (regSel == cp0Pkg::regEpc);

	assign ie = sr[0];
	assign exl = sr[1];

	//////////////////////////////////////////////////////////////////////
	// Exception entry values
	//////////////////////////////////////////////////////////////////////

	assign alignedPc = {pc[31:2], 2'b00};

	// Restart at the branch when the faulting word is in its delay slot
	assign excEpc = wbDelay ? (alignedPc - 32'd4) : alignedPc;

	// BD, pending lines and code
	assign excCause = {wbDelay, 15'd0, hwInt, 3'd0, code, 2'b00};

	//////////////////////////////////////////////////////////////////////
	// Register updates
	//////////////////////////////////////////////////////////////////////

	// Status
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sr <= cp0Pkg::srReset;
		end
		else if (excTaken)
		begin
			sr[1] <= 1'b1;
		end
		else if (isEret)
		begin
			sr[1] <= 1'b0;
		end
		else if (writeSr)
		begin
			sr <= dataIn;
		end
	end

	// Exception PC
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			epc <= '0;
		end
		else if (excTaken)
		begin
			epc <= excEpc;
		end
		else if (writeEpc)
		begin
			epc <= dataIn;
		end
	end

	// Cause is read only for software
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cause <= '0;
		end
		else if (excTaken)
		begin
			cause <= excCause;
		end
		else
		begin
			// IP field tracks the lines between exceptions
			cause[15:10] <= hwInt;
		end
	end

	// Processor id holds its reset value
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prid <= cp0Pkg::pridValue;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		dataOut = '0;
		case (op)
			cp0Pkg::opMfc0:
			begin
				case (regSel)
					cp0Pkg::regSr:
					begin
						dataOut = sr;
					end
					cp0Pkg::regCause:
					begin
						dataOut = cause;
					end
					cp0Pkg::regEpc:
					begin
						dataOut = epc;
					end
					cp0Pkg::regPrid:
					begin
						dataOut = prid;
					end
					default:
					begin
						dataOut = '0;
					end
				endcase
			end
			// Return address for the fetch stage
			cp0Pkg::opEret:
			begin
				dataOut = epc;
			end
			default:
			begin
				dataOut = '0;
			end
		endcase
	end

endmodule

// File: cp0Unit.sv
`timescale 1ns/10ps

module cp0Unit
(
	input logic clk,
	input logic reset,
	input cp0Pkg::word instr,
	input cp0Pkg::word wbInstr,
	input cp0Pkg::word pc,
	input cp0Pkg::word dataIn,
	input logic err,
	input cp0Pkg::excCode errStat,
	input cp0Pkg::intLines hwInt,
	output logic excTaken,
	output cp0Pkg::word dataOut
);

	// Decoder to register file
	cp0Pkg::cp0Op op;
	cp0Pkg::regNum regSel;
	logic wbDelay;

	// Status bits back to the priority logic
	logic ie;
	logic exl;

	// Exception code for Cause
	cp0Pkg::excCode code;

	instrDecode i_instrDecode
	(
		.instr(instr),
		.wbInstr(wbInstr),
		.op(op),
		.regSel(regSel),
		.wbDelay(wbDelay)
	);

	excPriority i_excPriority
	(
		.err(err),
		.errStat(errStat),
		.hwInt(hwInt),
		.ie(ie),
		.exl(exl),
		.excTaken(excTaken),
		.code(code)
	);

	cp0Regs i_cp0Regs
	(
		.clk(clk),
		.reset(reset),
		.op(op),
		.regSel(regSel),
		.wbDelay(wbDelay),
		.pc(pc),
		.dataIn(dataIn),
		.hwInt(hwInt),
		.excTaken(excTaken),
		.code(code),
		.ie(ie),
		.exl(exl),
		.dataOut(dataOut)
	);

endmodule

// File: cp0Unit_properties.sv
`timescale 1ns/10ps

module cp0Unit_properties
(
	input logic clk,
	input logic reset,
	input logic excTaken,
	input logic ie,
	input logic exl,
	input cp0Pkg::word prid
);

	// Failed assertions so far
	int failCount;

	initial
	begin
		failCount = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Status and id properties
	//////////////////////////////////////////////////////////////////////

	// Handler entry raises the exception level
	exlAfterException: assert property (@(posedge clk) disable iff (reset)
		excTaken |=> exl)
		else
		begin
			$error("EXL not set in the cycle after an exception");
			failCount++;
		end

	// IE set and EXL clear out of reset
	statusAfterReset: assert property (@(posedge clk)
		reset |=> (ie && !exl))
		else
		begin
			$error("SR not at its reset value after reset");
			failCount++;
		end

	// Fixed id word
	pridStable: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> $stable(prid))
		else
		begin
			$error("PRId changed outside reset");
			failCount++;
		end

endmodule

bind cp0Regs cp0Unit_properties i_cp0Unit_properties
(
	.clk(clk),
	.reset(reset),
	.excTaken(excTaken),
	.ie(ie),
	.exl(exl),
	.prid(prid)
);

// File: cp0Unit_tb.sv
`timescale 1ns/10ps

module cp0Unit_tb;

	localparam int resetCycles = 5;
	localparam int marginCycles = 20;

	// Raw instruction words
	localparam cp0Pkg::word nopWord = 32'h0000_0000;
	localparam cp0Pkg::word adduWord = 32'h0022_1821;
	localparam cp0Pkg::word eretWord = 32'h4200_0018;
	localparam cp0Pkg::word beqWord = 32'h1000_0003;
	localparam cp0Pkg::word jrWord = 32'h03e0_0008;

	// One cycle of stimulus and the expected response
	typedef struct
	{
		string name;
		cp0Pkg::word instr;
		cp0Pkg::word wbInstr;
		cp0Pkg::word pc;
		cp0Pkg::word dataIn;
		logic err;
		cp0Pkg::excCode errStat;
		cp0Pkg::intLines hwInt;
		logic expExc;
		cp0Pkg::word expData;
	} stimRow;

	logic clk;
	logic reset;
	cp0Pkg::word instr;
	cp0Pkg::word wbInstr;
	cp0Pkg::word pc;
	cp0Pkg::word dataIn;
	logic err;
	cp0Pkg::excCode errStat;
	cp0Pkg::intLines hwInt;
	logic excTaken;
	cp0Pkg::word dataOut;

	stimRow rows[$];
	int unsigned lcgState;
	int errorCount;
	int assertFailures;
	int cycleCount;
	int cycleLimit;
	logic rowFailed;

	cp0Unit i_cp0Unit
	(
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.wbInstr(wbInstr),
		.pc(pc),
		.dataIn(dataIn),
		.err(err),
		.errStat(errStat),
		.hwInt(hwInt),
		.excTaken(excTaken),
		.dataOut(dataOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic cp0Pkg::word nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic cp0Pkg::word mfc0Word(input cp0Pkg::regNum rd);
		return {6'b010000, 5'b00000, 5'd8, rd, 11'd0};
	endfunction

	function automatic cp0Pkg::word mtc0Word(input cp0Pkg::regNum rd);
		return {6'b010000, 5'b00100, 5'd8, rd, 11'd0};
	endfunction

	// Word aligned restart address
	function automatic cp0Pkg::word alignPc(input cp0Pkg::word p);
		return p & 32'hffff_fffc;
	endfunction

	// BD in bit 31, pending lines in 15:10, code in 6:2
	function automatic cp0Pkg::word causeWord(input logic bd, input cp0Pkg::intLines ip,
		input cp0Pkg::excCode c);
		return (cp0Pkg::word'(bd) << 31) | (cp0Pkg::word'(ip) << 10) | (cp0Pkg::word'(c) << 2);
	endfunction

	task automatic pushRow(input string name, input cp0Pkg::word ins, input cp0Pkg::word wb,
		input cp0Pkg::word p, input cp0Pkg::word din, input logic e, input cp0Pkg::excCode es,
		input cp0Pkg::intLines ip, input logic expExc, input cp0Pkg::word expData);
		stimRow r;
		r.name = name;
		r.instr = ins;
		r.wbInstr = wb;
		r.pc = p;
		r.dataIn = din;
		r.err = e;
		r.errStat = es;
		r.hwInt = ip;
		r.expExc = expExc;
		r.expData = expData;
		rows.push_back(r);
	endtask

	task automatic readBack(input string name, input cp0Pkg::regNum rd, input cp0Pkg::word exp);
		pushRow(name, mfc0Word(rd), nopWord, 32'd0, 32'd0, 1'b0, 5'd0, 6'd0, 1'b0, exp);
	endtask

	task automatic writeReg(input string name, input cp0Pkg::regNum rd, input cp0Pkg::word v);
		pushRow(name, mtc0Word(rd), nopWord, 32'd0, v, 1'b0, 5'd0, 6'd0, 1'b0, 32'd0);
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s excTaken: expected %0b, actual %0b", name, expected, actual);
			errorCount++;
			rowFailed = 1'b1;
		end
	endtask

	task automatic checkWord(input string name, input cp0Pkg::word expected,
		input cp0Pkg::word actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s dataOut: expected %h, actual %h", name, expected, actual);
			errorCount++;
			rowFailed = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic buildTable();
		cp0Pkg::word srVal;
		cp0Pkg::word epcVal;
		cp0Pkg::word p1;
		cp0Pkg::word p2;
		cp0Pkg::word p3;
		cp0Pkg::word p4;
		cp0Pkg::word p5;
		cp0Pkg::word lostVal;
		// IE kept set and EXL kept clear
		srVal = (nextRand() & ~32'h2) | 32'h1;
		epcVal = nextRand();
		p1 = nextRand();
		p2 = nextRand();
		p3 = nextRand();
		p4 = nextRand();
		p5 = nextRand();
		lostVal = nextRand();

		// Reset state
		readBack("rd_sr", 5'd12, 32'd1);
		readBack("rd_cause", 5'd13, 32'd0);
		readBack("rd_epc", 5'd14, 32'd0);
		readBack("rd_prid", 5'd15, cp0Pkg::pridValue);
		readBack("rd_reg9", 5'd9, 32'd0);
		pushRow("plain", adduWord, nopWord, 32'd0, 32'd0, 1'b0, 5'd0, 6'd0, 1'b0, 32'd0);

		// Register writes
		writeReg("wr_sr", 5'd12, srVal);
		readBack("rd_sr_back", 5'd12, srVal);
		writeReg("wr_epc", 5'd14, epcVal);
		readBack("rd_epc_back", 5'd14, epcVal);
		writeReg("wr_cause", 5'd13, nextRand());
		readBack("rd_cause_back", 5'd13, 32'd0);

		// Interrupt entry, then masked while EXL is set
		pushRow("irq_take", nopWord, nopWord, p1, 32'd0, 1'b0, 5'd0, 6'b000101, 1'b1, 32'd0);
		readBack("rd_cause_irq", 5'd13, causeWord(1'b0, 6'b000101, 5'd0));
		readBack("rd_epc_irq", 5'd14, alignPc(p1));
		pushRow("irq_masked", nopWord, nopWord, p2, 32'd0, 1'b0, 5'd0, 6'b100000, 1'b0, 32'd0);

		// Return and take again
		pushRow("eret", eretWord, nopWord, 32'd0, 32'd0, 1'b0, 5'd0, 6'd0, 1'b0, alignPc(p1));
		pushRow("irq_again", nopWord, nopWord, p2, 32'd0, 1'b0, 5'd0, 6'b000010, 1'b1, 32'd0);
		pushRow("eret2", eretWord, nopWord, 32'd0, 32'd0, 1'b0, 5'd0, 6'd0, 1'b0, alignPc(p2));

		// Errors in delay slots
		pushRow("err_beq", nopWord, beqWord, p3, 32'd0, 1'b1, 5'd12, 6'd0, 1'b1, 32'd0);
		readBack("rd_cause_beq", 5'd13, causeWord(1'b1, 6'd0, 5'd12));
		readBack("rd_epc_beq", 5'd14, alignPc(p3) - 32'd4);
		pushRow("eret3", eretWord, nopWord, 32'd0, 32'd0, 1'b0, 5'd0, 6'd0, 1'b0,
			alignPc(p3) - 32'd4);
		pushRow("err_jr", nopWord, jrWord, p4, 32'd0, 1'b1, 5'd4, 6'd0, 1'b1, 32'd0);
		readBack("rd_epc_jr", 5'd14, alignPc(p4) - 32'd4);
		readBack("rd_cause_jr", 5'd13, causeWord(1'b1, 6'd0, 5'd4));
		pushRow("eret4", eretWord, nopWord, 32'd0, 32'd0, 1'b0, 5'd0, 6'd0, 1'b0,
			alignPc(p4) - 32'd4);

		// Global disable
		writeReg("wr_sr_zero", 5'd12, 32'd0);
		pushRow("req_ignored", nopWord, nopWord, p5, 32'd0, 1'b1, 5'd3, 6'b111111, 1'b0, 32'd0);
		// Pending lines show up without an exception
		readBack("rd_cause_ip", 5'd13, causeWord(1'b1, 6'b111111, 5'd4));
		readBack("rd_sr_zero", 5'd12, 32'd0);
		writeReg("wr_sr_one", 5'd12, 32'd1);

		// Interrupt beats error, mtc0 to EPC lost
		pushRow("err_and_irq", mtc0Word(5'd14), nopWord, p5, lostVal, 1'b1, 5'd7, 6'b010000,
			1'b1, 32'd0);
		readBack("rd_cause_prio", 5'd13, causeWord(1'b0, 6'b010000, 5'd0));
		readBack("rd_epc_prio", 5'd14, alignPc(p5));
		readBack("rd_sr_prio", 5'd12, 32'd3);
		pushRow("eret5", eretWord, nopWord, 32'd0, 32'd0, 1'b0, 5'd0, 6'd0, 1'b0, alignPc(p5));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		int i;
		reset = 1'b1;
		instr = nopWord;
		wbInstr = nopWord;
		pc = '0;
		dataIn = '0;
		err = 1'b0;
		errStat = '0;
		hwInt = '0;
		errorCount = 0;
		assertFailures = 0;
		cycleCount = 0;
		cycleLimit = 0;
		rowFailed = 1'b0;
		lcgState = 8894;
		buildTable();
		cycleLimit = rows.size() + resetCycles + marginCycles;

		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		for (i = 0; i < rows.size(); i++)
		begin
			@(posedge clk);
			instr <= rows[i].instr;
			wbInstr <= rows[i].wbInstr;
			pc <= rows[i].pc;
			dataIn <= rows[i].dataIn;
			err <= rows[i].err;
			errStat <= rows[i].errStat;
			hwInt <= rows[i].hwInt;
			// Outputs are combinational, settled by the falling edge
			@(negedge clk);
			rowFailed = 1'b0;
			checkFlag(rows[i].name, rows[i].expExc, excTaken);
			checkWord(rows[i].name, rows[i].expData, dataOut);
			if (rowFailed)
			begin
				$display("test %s: failed", rows[i].name);
			end
			else
			begin
				$display("test %s: ok", rows[i].name);
			end
		end

		assertFailures = i_cp0Unit.i_cp0Regs.i_cp0Unit_properties.failCount;
		$display("%0d tests run, %0d checks failed, %0d assertions failed", rows.size(),
			errorCount, assertFailures);
		if (errorCount == 0 && assertFailures == 0)
		begin
			$display("RESULT: PASS");
		end
		else
		begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: list.f
cp0Pkg.sv
instrDecode.sv
excPriority.sv
cp0Regs.sv
cp0Unit.sv
cp0Unit_properties.sv
cp0Unit_tb.sv

// File: Makefile
TOP = cp0Unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

obj_dir/V$(TOP): list.f *.sv
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
